// File: include/decap_defines.svh
`ifndef DECAP_DEFINES_SVH
`define DECAP_DEFINES_SVH

// hash table index width, so each table holds 16 buckets.
`define DECAP_DEPTH_NBITS 4

// value memory index width.
`define DECAP_VALUE_DEPTH_NBITS 8

// lookup key width.
`define DECAP_KEY_NBITS 32

// address and data width of the PIO register port.
`define DECAP_PIO_NBITS 32

// width of the two wide value slices.
`define DECAP_WM_NBITS 64

`endif

// File: hdl/decap_pkg.sv
`include "decap_defines.svh"

package decap_pkg;

	// one hash table bucket, 64 bits wide.
	typedef struct packed {
		logic valid;
		logic [22:0] rsvd; // pads the bucket out to two PIO words.
		logic [`DECAP_KEY_NBITS-1:0] key;
		logic [`DECAP_VALUE_DEPTH_NBITS-1:0] vptr; // index into the value memory.
	} rci_bucket_t;

	// payloads of the wide and narrow value slices.
	typedef logic [`DECAP_WM_NBITS-1:0] rci_wslice_t;
	typedef logic [`DECAP_PIO_NBITS-1:0] rci_nslice_t;

	// slice 0 holds hi, slice 1 holds mid and slice 2 holds lo.
	typedef struct packed {
		rci_wslice_t hi;
		rci_wslice_t mid;
		rci_nslice_t lo;
	} rci_value_t;

	// result of one lookup; the value is zero on a miss.
	typedef struct packed {
		logic hit;
		rci_value_t value;
	} rci_result_t;

endpackage

// File: hdl/pio_mem.sv
`timescale 1ns/1ns
`include "decap_defines.svh"

module pio_mem #(
	parameter type entry_t = logic [`DECAP_PIO_NBITS-1:0],
	parameter int DEPTH_NBITS = `DECAP_DEPTH_NBITS
) (
	input logic clk,
	input logic rst_n,
	input logic clk_div,

	input logic [`DECAP_PIO_NBITS-1:0] reg_addr,
	input logic [`DECAP_PIO_NBITS-1:0] reg_din,
	input logic reg_rd,
	input logic reg_wr,
	input logic reg_ms,

	input logic app_mem_rd,
	input logic [DEPTH_NBITS-1:0] app_mem_raddr,

	output logic mem_ack,
	output logic [`DECAP_PIO_NBITS-1:0] mem_rdata,

	output logic app_mem_ack,
	output entry_t app_mem_rdata
);

	localparam int PIO_NBITS = `DECAP_PIO_NBITS;
	localparam int ENTRY_NBITS = $bits(entry_t);
	localparam int NWORDS = (ENTRY_NBITS + PIO_NBITS - 1) / PIO_NBITS; // PIO words per entry.
	localparam int WSEL_NBITS = $clog2(NWORDS);
	localparam int WSEL_W = (WSEL_NBITS > 0) ? WSEL_NBITS : 1;
	localparam int LINE_NBITS = NWORDS * PIO_NBITS;
	localparam int DEPTH = 1 << DEPTH_NBITS;

	logic [LINE_NBITS-1:0] mem [DEPTH];
	logic [LINE_NBITS-1:0] stage; // words written ahead of the commit.
	logic [LINE_NBITS-1:0] commit_line;
	logic [PIO_NBITS-3:0] reg_dw;
	logic [WSEL_W-1:0] wsel;
	logic [DEPTH_NBITS-1:0] idx;
	logic last_word;
	logic req;
	logic req_pend;
	logic pend_wr;
	logic act;
	logic act_wr;

	// the word select sits in the low dword bits, the entry index right above it.
	assign reg_dw = reg_addr[PIO_NBITS-1:2];
	assign wsel = (NWORDS > 1) ? reg_dw[WSEL_W-1:0] : '0;
	assign idx = reg_dw[WSEL_NBITS +: DEPTH_NBITS];
	assign last_word = (wsel == WSEL_W'(NWORDS - 1));

	assign req = reg_ms & (reg_rd | reg_wr);
	assign act = clk_div & (req_pend | req); // a request is served on a clk_div cycle only.
	assign act_wr = req_pend ? pend_wr : reg_wr;

	// the highest word goes straight in, the rest come from the staging register.
	always_comb begin
		commit_line = stage;
		commit_line[(NWORDS-1)*PIO_NBITS +: PIO_NBITS] = reg_din;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_pend <= 1'b0;
			pend_wr <= 1'b0;
			mem_ack <= 1'b0;
			stage <= '0;
		end else begin
			mem_ack <= act;
			if (act) begin
				req_pend <= 1'b0;
			end else if (req) begin
				req_pend <= 1'b1; // hold the request until clk_div comes around.
				pend_wr <= reg_wr;
			end
			if (act && act_wr && !last_word)
				stage[wsel*PIO_NBITS +: PIO_NBITS] <= reg_din;
		end
	end

	// all buckets come out of reset invalid.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
		end else if (act && act_wr && last_word) begin
			mem[idx] <= commit_line;
		end
	end

	// PIO reads see the stored entry, never the staged words.
	always_ff @(posedge clk) begin
		if (act && !act_wr)
			mem_rdata <= mem[idx][wsel*PIO_NBITS +: PIO_NBITS];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			app_mem_ack <= 1'b0;
		else
			app_mem_ack <= app_mem_rd;
	end

	// a commit to the same index in the same cycle is not yet visible here.
	always_ff @(posedge clk) begin
		if (app_mem_rd)
			app_mem_rdata <= entry_t'(mem[app_mem_raddr][ENTRY_NBITS-1:0]);
	end

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(reg_rd && reg_wr));

	// the master waits for each ack, so acks never run back to back.
	a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		mem_ack |=> !mem_ack);

endmodule

// File: hdl/decap_mem_rci.sv
`timescale 1ns/1ns
`include "decap_defines.svh"

module decap_mem_rci (
	input logic clk,
	input logic rst_n,
	input logic clk_div,

	input logic [`DECAP_PIO_NBITS-1:0] reg_addr,
	input logic [`DECAP_PIO_NBITS-1:0] reg_din,
	input logic reg_rd,
	input logic reg_wr,
	input logic reg_ms_rci_hash_table,
	input logic reg_ms_rci_value,

	output logic rci_hash_table_mem_ack,
	output logic [`DECAP_PIO_NBITS-1:0] rci_hash_table_mem_rdata,
	output logic rci_value_mem_ack,
	output logic [`DECAP_PIO_NBITS-1:0] rci_value_mem_rdata,

	input logic rci_hash_table0_rd,
	input logic [`DECAP_DEPTH_NBITS-1:0] rci_hash_table0_raddr,
	input logic rci_hash_table1_rd,
	input logic [`DECAP_DEPTH_NBITS-1:0] rci_hash_table1_raddr,
	input logic rci_value_rd,
	input logic [`DECAP_VALUE_DEPTH_NBITS-1:0] rci_value_raddr,

	output logic rci_hash_table0_ack,
	output decap_pkg::rci_bucket_t rci_hash_table0_rdata,
	output logic rci_hash_table1_ack,
	output decap_pkg::rci_bucket_t rci_hash_table1_rdata,
	output logic rci_value_ack,
	output decap_pkg::rci_value_t rci_value_rdata
);

	import decap_pkg::*;

	localparam int TBL_SEL_BIT = `DECAP_DEPTH_NBITS + 1; // dword bit that picks table 1.

	logic [`DECAP_PIO_NBITS-3:0] reg_dw;
	logic [2:0] reg_qw;
	logic sel_ht0;
	logic sel_ht1;
	logic sel_v0;
	logic sel_v1;
	logic sel_v2;
	logic sel_hole;
	logic [`DECAP_PIO_NBITS-1:0] value_wide_addr;
	logic [`DECAP_PIO_NBITS-1:0] value_narrow_addr;
	logic ht0_mem_ack;
	logic ht1_mem_ack;
	logic v0_mem_ack;
	logic v1_mem_ack;
	logic v2_mem_ack;
	logic [`DECAP_PIO_NBITS-1:0] ht0_mem_rdata;
	logic [`DECAP_PIO_NBITS-1:0] ht1_mem_rdata;
	logic [`DECAP_PIO_NBITS-1:0] v0_mem_rdata;
	logic [`DECAP_PIO_NBITS-1:0] v1_mem_rdata;
	logic [`DECAP_PIO_NBITS-1:0] v2_mem_rdata;
	logic hole_req;
	logic hole_pend;
	logic hole_ack;
	rci_wslice_t value_hi;
	rci_wslice_t value_mid;
	rci_nslice_t value_lo;

	assign reg_dw = reg_addr[`DECAP_PIO_NBITS-1:2];
	assign reg_qw = reg_addr[5:3];

	assign sel_ht0 = reg_ms_rci_hash_table & ~reg_dw[TBL_SEL_BIT];
	assign sel_ht1 = reg_ms_rci_hash_table & reg_dw[TBL_SEL_BIT];
	assign sel_v0 = reg_ms_rci_value & (reg_qw == 3'd0);
	assign sel_v1 = reg_ms_rci_value & (reg_qw == 3'd1);
	assign sel_v2 = reg_ms_rci_value & (reg_qw == 3'd2) & ~reg_addr[2];
	assign sel_hole = reg_ms_rci_value & ~((reg_qw == 3'd0) | (reg_qw == 3'd1) |
		((reg_qw == 3'd2) & ~reg_addr[2]));

	// drop the qword field so the index lands right above each slice's word select.
	assign value_wide_addr = {3'b000, reg_addr[`DECAP_PIO_NBITS-1:6], reg_addr[2:0]};
	assign value_narrow_addr = {4'b0000, reg_addr[`DECAP_PIO_NBITS-1:6], reg_addr[1:0]};

	pio_mem #(.entry_t(rci_bucket_t), .DEPTH_NBITS(`DECAP_DEPTH_NBITS)) u_ht0 (
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div),
		.reg_addr(reg_addr), .reg_din(reg_din), .reg_rd(reg_rd), .reg_wr(reg_wr),
		.reg_ms(sel_ht0),
		.app_mem_rd(rci_hash_table0_rd), .app_mem_raddr(rci_hash_table0_raddr),
		.mem_ack(ht0_mem_ack), .mem_rdata(ht0_mem_rdata),
		.app_mem_ack(rci_hash_table0_ack), .app_mem_rdata(rci_hash_table0_rdata)
	);

	pio_mem #(.entry_t(rci_bucket_t), .DEPTH_NBITS(`DECAP_DEPTH_NBITS)) u_ht1 (
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div),
		.reg_addr(reg_addr), .reg_din(reg_din), .reg_rd(reg_rd), .reg_wr(reg_wr),
		.reg_ms(sel_ht1),
		.app_mem_rd(rci_hash_table1_rd), .app_mem_raddr(rci_hash_table1_raddr),
		.mem_ack(ht1_mem_ack), .mem_rdata(ht1_mem_rdata),
		.app_mem_ack(rci_hash_table1_ack), .app_mem_rdata(rci_hash_table1_rdata)
	);

	// slice 0 paces the value read, the other slices answer in the same cycle.
	pio_mem #(.entry_t(rci_wslice_t), .DEPTH_NBITS(`DECAP_VALUE_DEPTH_NBITS)) u_value0 (
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div),
		.reg_addr(value_wide_addr), .reg_din(reg_din), .reg_rd(reg_rd), .reg_wr(reg_wr),
		.reg_ms(sel_v0),
		.app_mem_rd(rci_value_rd), .app_mem_raddr(rci_value_raddr),
		.mem_ack(v0_mem_ack), .mem_rdata(v0_mem_rdata),
		.app_mem_ack(rci_value_ack), .app_mem_rdata(value_hi)
	);

	pio_mem #(.entry_t(rci_wslice_t), .DEPTH_NBITS(`DECAP_VALUE_DEPTH_NBITS)) u_value1 (
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div),
		.reg_addr(value_wide_addr), .reg_din(reg_din), .reg_rd(reg_rd), .reg_wr(reg_wr),
		.reg_ms(sel_v1),
		.app_mem_rd(rci_value_rd), .app_mem_raddr(rci_value_raddr),
		.mem_ack(v1_mem_ack), .mem_rdata(v1_mem_rdata),
		.app_mem_ack(), .app_mem_rdata(value_mid)
	);

	pio_mem #(.entry_t(rci_nslice_t), .DEPTH_NBITS(`DECAP_VALUE_DEPTH_NBITS)) u_value2 (
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div),
		.reg_addr(value_narrow_addr), .reg_din(reg_din), .reg_rd(reg_rd), .reg_wr(reg_wr),
		.reg_ms(sel_v2),
		.app_mem_rd(rci_value_rd), .app_mem_raddr(rci_value_raddr),
		.mem_ack(v2_mem_ack), .mem_rdata(v2_mem_rdata),
		.app_mem_ack(), .app_mem_rdata(value_lo)
	);

	assign rci_value_rdata = '{hi: value_hi, mid: value_mid, lo: value_lo};

	// unmapped value words are acknowledged on the next clk_div cycle.
	assign hole_req = sel_hole & (reg_rd | reg_wr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hole_pend <= 1'b0;
			hole_ack <= 1'b0;
		end else begin
			hole_ack <= clk_div & (hole_pend | hole_req);
			if (clk_div)
				hole_pend <= 1'b0;
			else if (hole_req)
				hole_pend <= 1'b1;
		end
	end

	always_comb begin
		rci_hash_table_mem_ack = reg_dw[TBL_SEL_BIT] ? ht1_mem_ack : ht0_mem_ack;
		rci_hash_table_mem_rdata = reg_dw[TBL_SEL_BIT] ? ht1_mem_rdata : ht0_mem_rdata;
		rci_value_mem_ack = hole_ack; // the hole reads back as zero.
		rci_value_mem_rdata = '0;
		case (reg_qw)
			3'd0: begin
				rci_value_mem_ack = v0_mem_ack;
				rci_value_mem_rdata = v0_mem_rdata;
			end
			3'd1: begin
				rci_value_mem_ack = v1_mem_ack;
				rci_value_mem_rdata = v1_mem_rdata;
			end
			3'd2: begin
				if (!reg_addr[2]) begin
					rci_value_mem_ack = v2_mem_ack;
					rci_value_mem_rdata = v2_mem_rdata;
				end
			end
			default: ;
		endcase
	end

	a_one_sel: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({sel_ht0, sel_ht1, sel_v0, sel_v1, sel_v2, sel_hole}));

endmodule

// File: hdl/rci_lookup.sv
`timescale 1ns/1ns
`include "decap_defines.svh"

module rci_lookup (
	input logic clk,
	input logic rst_n,

	input logic key_valid,
	input logic [`DECAP_KEY_NBITS-1:0] key,

	output logic rci_hash_table0_rd,
	output logic [`DECAP_DEPTH_NBITS-1:0] rci_hash_table0_raddr,
	output logic rci_hash_table1_rd,
	output logic [`DECAP_DEPTH_NBITS-1:0] rci_hash_table1_raddr,
	output logic rci_value_rd,
	output logic [`DECAP_VALUE_DEPTH_NBITS-1:0] rci_value_raddr,

	input logic rci_hash_table0_ack,
	input decap_pkg::rci_bucket_t rci_hash_table0_rdata,
	input logic rci_hash_table1_ack,
	input decap_pkg::rci_bucket_t rci_hash_table1_rdata,
	input logic rci_value_ack,
	input decap_pkg::rci_value_t rci_value_rdata,

	output logic result_valid,
	output decap_pkg::rci_result_t result
);

	import decap_pkg::*;

	localparam int HASH_NBITS = `DECAP_DEPTH_NBITS;
	localparam int NCHUNKS = `DECAP_KEY_NBITS / HASH_NBITS;

	logic [`DECAP_KEY_NBITS-1:0] s1_key;
	logic s1_valid;
	logic hit0;
	logic hit1;
	logic s1_hit;
	logic [`DECAP_VALUE_DEPTH_NBITS-1:0] s1_vptr;
	logic s2_hit;
	rci_value_t value_masked;

	// folds every other key chunk together, starting at the given chunk.
	function automatic logic [HASH_NBITS-1:0] fold_key(
		input logic [`DECAP_KEY_NBITS-1:0] k,
		input int first
	);
		logic [HASH_NBITS-1:0] acc;
		acc = '0;
		for (int n = first; n < NCHUNKS; n += 2)
			acc ^= k[n*HASH_NBITS +: HASH_NBITS];
		return acc;
	endfunction

	// stage 0 issues both bucket reads straight from the key.
	assign rci_hash_table0_rd = key_valid;
	assign rci_hash_table1_rd = key_valid;
	assign rci_hash_table0_raddr = fold_key(key, 0); // even nibbles.
	assign rci_hash_table1_raddr = fold_key(key, 1); // odd nibbles.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= key_valid;
	end

	always_ff @(posedge clk) begin
		s1_key <= key;
	end

	// stage 1 compares both buckets; table 0 wins when both match.
	assign hit0 = rci_hash_table0_rdata.valid && (rci_hash_table0_rdata.key == s1_key);
	assign hit1 = rci_hash_table1_rdata.valid && (rci_hash_table1_rdata.key == s1_key);
	assign s1_hit = hit0 | hit1;
	assign s1_vptr = hit0 ? rci_hash_table0_rdata.vptr : rci_hash_table1_rdata.vptr;

	// the value read goes out on a miss as well, which keeps the latency fixed.
	assign rci_value_rd = s1_valid;
	assign rci_value_raddr = s1_vptr;

	always_ff @(posedge clk) begin
		s2_hit <= s1_hit;
	end

	// stage 2 masks the record on a miss and registers the result.
	assign value_masked = s2_hit ? rci_value_rdata : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			result_valid <= 1'b0;
		else
			result_valid <= rci_value_ack;
	end

	always_ff @(posedge clk) begin
		result <= '{hit: s2_hit, value: value_masked};
	end

	// the bucket memories must answer exactly one cycle after each read.
	a_ht0_ack: assert property (@(posedge clk) disable iff (!rst_n)
		rci_hash_table0_rd |=> rci_hash_table0_ack);

	a_ht1_ack: assert property (@(posedge clk) disable iff (!rst_n)
		rci_hash_table1_rd |=> rci_hash_table1_ack);

endmodule

// File: hdl/rci_top.sv
`timescale 1ns/1ns
`include "decap_defines.svh"

module rci_top (
	input logic clk,
	input logic rst_n,
	input logic clk_div,

	input logic [`DECAP_PIO_NBITS-1:0] reg_addr,
	input logic [`DECAP_PIO_NBITS-1:0] reg_din,
	input logic reg_rd,
	input logic reg_wr,
	input logic reg_ms_rci_hash_table,
	input logic reg_ms_rci_value,
	output logic rci_hash_table_mem_ack,
	output logic [`DECAP_PIO_NBITS-1:0] rci_hash_table_mem_rdata,
	output logic rci_value_mem_ack,
	output logic [`DECAP_PIO_NBITS-1:0] rci_value_mem_rdata,

	input logic key_valid,
	input logic [`DECAP_KEY_NBITS-1:0] key,
	output logic result_valid,
	output decap_pkg::rci_result_t result
);

	import decap_pkg::*;

	// read ports between the lookup engine and the memories.
	logic rci_hash_table0_rd;
	logic [`DECAP_DEPTH_NBITS-1:0] rci_hash_table0_raddr;
	logic rci_hash_table1_rd;
	logic [`DECAP_DEPTH_NBITS-1:0] rci_hash_table1_raddr;
	logic rci_value_rd;
	logic [`DECAP_VALUE_DEPTH_NBITS-1:0] rci_value_raddr;
	logic rci_hash_table0_ack;
	rci_bucket_t rci_hash_table0_rdata;
	logic rci_hash_table1_ack;
	rci_bucket_t rci_hash_table1_rdata;
	logic rci_value_ack;
	rci_value_t rci_value_rdata;

	rci_lookup u_rci_lookup (.*);

	decap_mem_rci u_decap_mem_rci (.*);

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
	parameter int PERIOD = 100,
	parameter int RST_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// reset is released on a rising edge after RST_CYCLES cycles.
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: dv/rci_tb.sv
`timescale 1ns/1ns
`include "decap_defines.svh"

module rci_tb;

	import decap_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int PIO_OPS = 140; // rough count of PIO accesses over all tests.
	localparam int PIO_OP_CYCLES = 6;
	localparam int LOOKUPS = 90;
	localparam int TIMEOUT_CYCLES = PIO_OPS * PIO_OP_CYCLES + LOOKUPS * 2 + 200;
	localparam int NBUCKETS = 1 << `DECAP_DEPTH_NBITS;

	logic clk;
	logic rst_n;
	logic clk_div;
	logic [`DECAP_PIO_NBITS-1:0] reg_addr;
	logic [`DECAP_PIO_NBITS-1:0] reg_din;
	logic reg_rd;
	logic reg_wr;
	logic reg_ms_rci_hash_table;
	logic reg_ms_rci_value;
	logic rci_hash_table_mem_ack;
	logic [`DECAP_PIO_NBITS-1:0] rci_hash_table_mem_rdata;
	logic rci_value_mem_ack;
	logic [`DECAP_PIO_NBITS-1:0] rci_value_mem_rdata;
	logic key_valid;
	logic [`DECAP_KEY_NBITS-1:0] key;
	logic result_valid;
	rci_result_t result;

	// reference model of both tables, the value memory and the staging words.
	logic [63:0] ht_model [2*NBUCKETS];
	logic [31:0] ht_stage [2];
	logic [159:0] val_model [1 << `DECAP_VALUE_DEPTH_NBITS];
	logic [31:0] val_stage [2];
	logic [160:0] exp_q [$];
	int issue_q [$];
	logic [31:0] keys_q [$];
	logic [31:0] installed [$];
	int cyc = 0;
	int checks = 0;
	int errors = 0;
	int proto_errors = 0;
	integer seed;

	tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(3)) u_clk_gen (.clk(clk), .rst_n(rst_n));

	rci_top rci_top_i (.*);

	function automatic logic [3:0] hash_even(input logic [31:0] k);
		return k[3:0] ^ k[11:8] ^ k[19:16] ^ k[27:24];
	endfunction

	function automatic logic [3:0] hash_odd(input logic [31:0] k);
		return k[7:4] ^ k[15:12] ^ k[23:20] ^ k[31:28];
	endfunction

	function automatic logic [31:0] ht_addr(input logic t, input logic [3:0] idx, input logic half);
		return {24'h0, t, idx, half, 2'b00};
	endfunction

	function automatic logic [31:0] val_addr(input logic [7:0] idx, input logic [2:0] qw,
		input logic w);
		return {18'h0, idx, qw, w, 2'b00};
	endfunction

	// table 0 is tried first; a miss gives hit 0 and a zero value.
	function automatic logic [160:0] predict(input logic [31:0] k);
		logic [63:0] b0;
		logic [63:0] b1;
		b0 = ht_model[{1'b0, hash_even(k)}];
		b1 = ht_model[{1'b1, hash_odd(k)}];
		if (b0[63] && b0[39:8] == k)
			return {1'b1, val_model[b0[7:0]]};
		if (b1[63] && b1[39:8] == k)
			return {1'b1, val_model[b1[7:0]]};
		return '0;
	endfunction

	// lower words wait in staging until the top word of the entry arrives.
	function automatic void model_write(input logic is_value, input logic [31:0] a,
		input logic [31:0] d);
		logic [2:0] qw;
		qw = a[5:3];
		if (!is_value) begin
			if (!a[2])
				ht_stage[a[7]] = d;
			else
				ht_model[{a[7], a[6:3]}] = {d, ht_stage[a[7]]};
		end else if (qw == 3'd0 || qw == 3'd1) begin
			if (!a[2])
				val_stage[qw[0]] = d;
			else if (qw == 3'd0)
				val_model[a[13:6]][159:96] = {d, val_stage[0]};
			else
				val_model[a[13:6]][95:32] = {d, val_stage[1]};
		end else if (qw == 3'd2 && !a[2]) begin
			val_model[a[13:6]][31:0] = d;
		end
	endfunction

	function automatic logic [31:0] model_read(input logic is_value, input logic [31:0] a);
		logic [63:0] b;
		logic [159:0] v;
		b = ht_model[{a[7], a[6:3]}];
		v = val_model[a[13:6]];
		if (!is_value)
			return a[2] ? b[63:32] : b[31:0];
		case (a[5:3])
			3'd0: return a[2] ? v[159:128] : v[127:96];
			3'd1: return a[2] ? v[95:64] : v[63:32];
			3'd2: return a[2] ? 32'h0 : v[31:0];
			default: return 32'h0; // unmapped words read as zero.
		endcase
	endfunction

	task automatic check_val(input string name, input logic [191:0] got,
		input logic [191:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, want);
		end
	endtask

	task automatic pio_access(input logic is_value, input logic is_wr, input logic [31:0] a,
		input logic [31:0] d, output logic [31:0] rdata);
		int n;
		logic got;
		n = 0;
		got = 1'b0;
		rdata = '0;
		@(posedge clk);
		reg_addr <= a;
		reg_din <= d;
		reg_rd <= !is_wr;
		reg_wr <= is_wr;
		reg_ms_rci_hash_table <= !is_value;
		reg_ms_rci_value <= is_value;
		@(posedge clk);
		reg_rd <= 1'b0; // the request is a single-cycle strobe.
		reg_wr <= 1'b0;
		while (!got && n < 8) begin
			@(negedge clk);
			n++;
			if (is_value ? rci_value_mem_ack : rci_hash_table_mem_ack) begin
				got = 1'b1;
				rdata = is_value ? rci_value_mem_rdata : rci_hash_table_mem_rdata;
			end
		end
		if (!got) begin
			proto_errors++;
			$display("no PIO ack within 8 cycles for the access at address 0x%h", a);
		end
	endtask

	task automatic pio_write(input logic is_value, input logic [31:0] a, input logic [31:0] d);
		logic [31:0] unused;
		pio_access(is_value, 1'b1, a, d, unused);
		model_write(is_value, a, d);
	endtask

	task automatic pio_read(input logic is_value, input logic [31:0] a);
		logic [31:0] rd;
		string name;
		pio_access(is_value, 1'b0, a, 32'h0, rd);
		if (is_value)
			name = "rci_value_mem_rdata";
		else
			name = "rci_hash_table_mem_rdata";
		check_val(name, 192'(rd), 192'(model_read(is_value, a)));
	endtask

	task automatic install_bucket(input logic t, input logic [31:0] k, input logic [7:0] vptr);
		logic [3:0] idx;
		idx = t ? hash_odd(k) : hash_even(k);
		pio_write(1'b0, ht_addr(t, idx, 1'b0), {k[23:0], vptr});
		pio_write(1'b0, ht_addr(t, idx, 1'b1), {1'b1, 23'h0, k[31:24]});
	endtask

	task automatic install_value(input logic [7:0] idx, input logic [159:0] v);
		pio_write(1'b1, val_addr(idx, 3'd0, 1'b0), v[127:96]);
		pio_write(1'b1, val_addr(idx, 3'd0, 1'b1), v[159:128]);
		pio_write(1'b1, val_addr(idx, 3'd1, 1'b0), v[63:32]);
		pio_write(1'b1, val_addr(idx, 3'd1, 1'b1), v[95:64]);
		pio_write(1'b1, val_addr(idx, 3'd2, 1'b0), v[31:0]);
	endtask

	// drives the queued keys on back-to-back cycles.
	task automatic drive_stream();
		foreach (keys_q[i]) begin
			@(posedge clk);
			key_valid <= 1'b1;
			key <= keys_q[i];
		end
		@(posedge clk);
		key_valid <= 1'b0;
		keys_q.delete();
	endtask

	task automatic wait_results();
		int n;
		n = 0;
		while (exp_q.size() > 0 && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() > 0) begin
			proto_errors++;
			$display("%0d lookup results never arrived", exp_q.size());
			exp_q.delete();
			issue_q.delete();
		end
	endtask

	task automatic lookup(input logic [31:0] k);
		keys_q.push_back(k);
		drive_stream();
		wait_results();
	endtask

	// each result must come exactly three cycles after its key, in order.
	task automatic monitor_results();
		logic [160:0] want;
		int issued;
		forever begin
			@(negedge clk);
			cyc++;
			if (rst_n && key_valid) begin
				exp_q.push_back(predict(key));
				issue_q.push_back(cyc);
			end
			if (rst_n && result_valid) begin
				if (exp_q.size() == 0) begin
					proto_errors++;
					$display("result_valid came with no lookup in flight");
				end else begin
					want = exp_q.pop_front();
					issued = issue_q.pop_front();
					check_val("result_valid latency", 192'(cyc - issued), 192'(3));
					check_val("result", 192'(result), 192'(want));
				end
			end
		end
	endtask

	initial begin
		logic [159:0] rec;
		logic [31:0] k;
		seed = 68013;
		clk_div <= 1'b0;
		reg_addr <= '0;
		reg_din <= '0;
		reg_rd <= 1'b0;
		reg_wr <= 1'b0;
		reg_ms_rci_hash_table <= 1'b0;
		reg_ms_rci_value <= 1'b0;
		key_valid <= 1'b0;
		key <= '0;
		foreach (ht_model[i])
			ht_model[i] = '0;
		foreach (val_model[i])
			val_model[i] = '0;
		ht_stage = '{32'h0, 32'h0};
		val_stage = '{32'h0, 32'h0};
		fork
			forever @(posedge clk) clk_div <= ~clk_div; // high on every other cycle.
			monitor_results();
			begin
				#(TIMEOUT_CYCLES * CLK_PERIOD);
				$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
				$display("Verification failed");
				$finish;
			end
		join_none
		wait (rst_n === 1'b1);

		// nothing acks after reset, and every lookup misses.
		repeat (4) begin
			@(negedge clk);
			check_val("rci_hash_table_mem_ack", 192'(rci_hash_table_mem_ack), 192'(1'b0));
			check_val("rci_value_mem_ack", 192'(rci_value_mem_ack), 192'(1'b0));
			check_val("result_valid", 192'(result_valid), 192'(1'b0));
		end
		lookup(32'h0000_0000);
		lookup($random(seed));

		// bucket readback, then a lone low-half write that must stay staged.
		pio_write(1'b0, ht_addr(1'b0, 4'd3, 1'b0), 32'h8765_4321);
		pio_write(1'b0, ht_addr(1'b0, 4'd3, 1'b1), 32'h8000_00ab);
		pio_write(1'b0, ht_addr(1'b1, 4'd9, 1'b0), 32'h1357_9bdf);
		pio_write(1'b0, ht_addr(1'b1, 4'd9, 1'b1), 32'h8024_6801);
		for (int i = 0; i < 2; i++) begin
			pio_read(1'b0, ht_addr(1'b0, 4'd3, 1'(i)));
			pio_read(1'b0, ht_addr(1'b1, 4'd9, 1'(i)));
		end
		pio_write(1'b0, ht_addr(1'b0, 4'd3, 1'b0), 32'hdead_beef);
		pio_read(1'b0, ht_addr(1'b0, 4'd3, 1'b0));
		pio_read(1'b0, ht_addr(1'b0, 4'd3, 1'b1));

		// value slices, then holes that read zero and drop writes.
		install_value(8'd5, 160'ha1a2a3a4_b1b2b3b4_c1c2c3c4_d1d2d3d4_e1e2e3e4);
		for (int i = 0; i < 2; i++) begin
			pio_read(1'b1, val_addr(8'd5, 3'd0, 1'(i)));
			pio_read(1'b1, val_addr(8'd5, 3'd1, 1'(i)));
		end
		pio_read(1'b1, val_addr(8'd5, 3'd2, 1'b0));
		for (int q = 2; q < 8; q++) begin
			pio_write(1'b1, val_addr(8'd5, 3'(q), 1'b1), 32'hffff_ffff);
			pio_read(1'b1, val_addr(8'd5, 3'(q), 1'b1));
		end
		pio_write(1'b1, val_addr(8'd5, 3'd3, 1'b0), 32'hffff_ffff);
		pio_read(1'b1, val_addr(8'd5, 3'd3, 1'b0));
		pio_read(1'b1, val_addr(8'd5, 3'd2, 1'b0));
		pio_read(1'b1, val_addr(8'd5, 3'd1, 1'b1));

		// table 0 hit, table 1 hit, both tables matching, and a key mismatch.
		install_bucket(1'b0, 32'h1234_5678, 8'd10);
		install_bucket(1'b1, 32'hcafe_0001, 8'd11);
		install_bucket(1'b0, 32'h0bad_f00d, 8'd12);
		install_bucket(1'b1, 32'h0bad_f00d, 8'd13);
		for (int i = 10; i < 14; i++) begin
			rec = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
			install_value(8'(i), rec);
		end
		lookup(32'h1234_5678);
		lookup(32'hcafe_0001);
		lookup(32'h0bad_f00d);
		lookup(32'h1234_5779); // same buckets as the first key.

		// random keys back to back, about half of them installed.
		for (int i = 0; i < 8; i++) begin
			k = $random(seed);
			installed.push_back(k);
			install_bucket(1'(i % 2), k, 8'(20 + i));
			rec = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
			install_value(8'(20 + i), rec);
		end
		for (int i = 0; i < 40; i++) begin
			k = $random(seed);
			if (k[0])
				keys_q.push_back(installed[k[3:1]]);
			else
				keys_q.push_back($random(seed));
		end
		drive_stream();
		wait_results();

		// PIO traffic while lookups stream; none of it touches live entries.
		for (int i = 0; i < 30; i++)
			keys_q.push_back(installed[i % 8]);
		fork
			drive_stream();
			begin
				pio_read(1'b0, ht_addr(1'b0, hash_even(installed[0]), 1'b1));
				pio_write(1'b1, val_addr(8'd250, 3'd2, 1'b0), 32'h0f0f_0f0f);
				pio_read(1'b1, val_addr(8'd250, 3'd2, 1'b0));
				pio_write(1'b0, ht_addr(1'b1, 4'd0, 1'b0), 32'h5555_aaaa);
				pio_read(1'b1, val_addr(8'd20, 3'd0, 1'b1));
				pio_read(1'b0, ht_addr(1'b1, hash_odd(installed[1]), 1'b0));
			end
		join
		wait_results();

		@(posedge clk);
		reg_ms_rci_hash_table <= 1'b0;
		reg_ms_rci_value <= 1'b0;
		repeat (4) @(negedge clk);
		$display("summary: %0d checks, %0d value errors, %0d protocol errors",
			checks, errors, proto_errors);
		if (errors == 0 && proto_errors == 0 && checks > 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+include
hdl/decap_pkg.sv
hdl/pio_mem.sv
hdl/decap_mem_rci.sv
hdl/rci_lookup.sv
hdl/rci_top.sv
dv/tb_clk_gen.sv
dv/rci_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f filelist.f --top-module rci_tb -o rci_sim; then
	echo "build failed"
	exit 1
fi

./obj_dir/rci_sim > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Verification passed$" sim.log; then
	exit 0
fi

echo "pass message not found in sim.log"
exit 1
